// ==== tb_input.txt ====
# columns in hex: I instruction word | D byte address, data word | S store address, data
# order of S lines is the order the stores must appear on dmem_req
I 20010035  addi $1, $0, 0x35
I 00211020  add  $2, $1, $1
I 00221822  sub  $3, $1, $2
I 00622024  and  $4, $3, $2
I 00812825  or   $5, $4, $1
I 0065302a  slt  $6, $3, $5
I 30c70003  andi $7, $6, 3
I ac070040  sw   $7, 0x40($0)
I ac050044  sw   $5, 0x44($0)
I ac040048  sw   $4, 0x48($0)
I ac03004c  sw   $3, 0x4c($0)
I 8c080080  lw   $8, 0x80($0)
I 21090001  addi $9, $8, 1
I ac090050  sw   $9, 0x50($0)
I 8c0a0084  lw   $10, 0x84($0)
I ac0a0054  sw   $10, 0x54($0)
I 11080002  beq  $8, $8, +2
I ac010058  sw   $1, 0x58($0)
I ac01005c  sw   $1, 0x5c($0)
I 14220001  bne  $1, $2, +1
I ac020058  sw   $2, 0x58($0)
I 10220001  beq  $1, $2, +1
I ac060058  sw   $6, 0x58($0)
I 14210001  bne  $1, $1, +1
I ac02005c  sw   $2, 0x5c($0)
I 0800001d  j    29
I ac010060  sw   $1, 0x60($0)
I ac010064  sw   $1, 0x64($0)
I ac010068  sw   $1, 0x68($0)
I ac080060  sw   $8, 0x60($0)
I 0800001e  j    30
D 00000080 12345678
D 00000084 00000100
S 00000040 00000001  andi of the slt result
S 00000044 0000007f  0x4a or 0x35
S 00000048 0000004a  0xffffffcb and 0x6a
S 0000004c ffffffcb  0x35 minus 0x6a
S 00000050 12345679  load plus one
S 00000054 00000100  loaded word stored back
S 00000058 00000001  after the not-taken beq
S 0000005c 0000006a  after the not-taken bne
S 00000060 12345678  jump target

// ==== flist.f ====
pipeline_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
hazard_unit.sv
execute_stage.sv
memory_stage.sv
cpu_top.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir
verilator --binary -Wno-fatal --top-module tb_cpu -f flist.f > build.log 2>&1 \
	&& ./obj_dir/Vtb_cpu > sim.log 2>&1 \
	|| { echo "build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu;

	localparam int prog_words   = 64;
	localparam int data_words   = 64;
	localparam int drain_cycles = 20; // idle time after the last store

	logic                    clk;
	logic                    reset;
	pipeline_pkg::word_t     imem_addr;
	pipeline_pkg::instr_t    imem_data;
	pipeline_pkg::dmem_req_t dmem_req;
	pipeline_pkg::word_t     dmem_rdata;

	pipeline_pkg::word_t     prog [prog_words];
	pipeline_pkg::word_t     dmem [data_words];
	pipeline_pkg::dmem_req_t exp_stores [$];

	int n_words      = 0;
	int store_idx    = 0;
	int cycles       = 0;
	int limit        = 0;
	int value_errors = 0;
	int extra_stores = 0;
	int timeouts     = 0;
	int file_errors  = 0;

	cpu_top DUT (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_req(dmem_req),
		.dmem_rdata(dmem_rdata)
	);

	always #50 clk = ~clk;

	always @(negedge clk)
		cycles++;

	task automatic check_word(input string name, input pipeline_pkg::word_t got,
			input pipeline_pkg::word_t exp);
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_store(input pipeline_pkg::dmem_req_t got,
			input pipeline_pkg::dmem_req_t exp);
		if (got.addr !== exp.addr)
		begin
			$display("Fail dmem_req.addr got %h expected %h", got.addr, exp.addr);
			value_errors++;
		end
		if (got.wdata !== exp.wdata)
		begin
			$display("Fail dmem_req.wdata got %h expected %h", got.wdata, exp.wdata);
			value_errors++;
		end
	endtask

	task automatic expect_reset_state;
		check_word("imem_addr", imem_addr, '0);
		compare_bit("dmem_req.write", dmem_req.write, 1'b0);
		compare_bit("dmem_req.read", dmem_req.read, 1'b0);
	endtask

	// I word, D addr data, S addr data; anything else is a comment
	task automatic load_input_file;
		int                      fd;
		int                      n;
		string                   line;
		byte                     kind;
		pipeline_pkg::word_t     a;
		pipeline_pkg::word_t     b;
		pipeline_pkg::dmem_req_t req;
		fd = $fopen("tb_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tb_input.txt");
			file_errors++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			kind = line.getc(0);
			n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
			case (kind)
				"I":
				begin
					if (n < 1 || n_words >= prog_words)
					begin
						$display("bad or surplus program line in tb_input.txt");
						file_errors++;
					end
					else
					begin
						prog[n_words] = a;
						n_words++;
					end
				end
				"D":
					if (n == 2)
						dmem[a[7:2]] = b;
					else
					begin
						$display("bad data line in tb_input.txt");
						file_errors++;
					end
				"S":
				begin
					req       = '0;
					req.addr  = a;
					req.wdata = b;
					req.write = 1'b1;
					if (n == 2)
						exp_stores.push_back(req);
					else
					begin
						$display("bad store line in tb_input.txt");
						file_errors++;
					end
				end
				default: ;
			endcase
		end
		$fclose(fd);
	endtask

	// both memory models answer from the falling edge on
	always @(negedge clk)
	begin
		if (dmem_req.write)
		begin
			if (store_idx < exp_stores.size())
				check_store(dmem_req, exp_stores[store_idx]);
			else
			begin
				$display("unexpected extra store of %h to address %h",
					dmem_req.wdata, dmem_req.addr);
				extra_stores++;
			end
			store_idx++;
			dmem[dmem_req.addr[7:2]] = dmem_req.wdata;
		end
		imem_data  = pipeline_pkg::instr_t'(prog[imem_addr[7:2]]);
		dmem_rdata = dmem_req.read ? dmem[dmem_req.addr[7:2]] : '0; // data only while read
	end

	initial
	begin
		clk        = 1'b0;
		reset      = 1'b1;
		imem_data  = '0;
		dmem_rdata = '0;
		for (int i = 0; i < prog_words; i++)
			prog[i] = 32'h2000_0000 | i; // addi $0, $0, index
		for (int i = 0; i < data_words; i++)
			dmem[i] = 32'hdada_0000 | (i << 2);
		load_input_file();
		limit = 8 * n_words + 50;

		repeat (3)
		begin
			@(negedge clk);
			expect_reset_state();
		end
		reset = 1'b0;
		#10;
		expect_reset_state(); // still before the first fetch edge

		while (store_idx < exp_stores.size() && cycles < limit)
			@(posedge clk);
		if (store_idx < exp_stores.size())
		begin
			$display("timeout after %0d cycles with %0d of %0d stores seen",
				cycles, store_idx, exp_stores.size());
			timeouts++;
		end
		else
			repeat (drain_cycles) @(posedge clk);

		$display("errors: values %0d, extra stores %0d, timeouts %0d, input file %0d",
			value_errors, extra_stores, timeouts, file_errors);
		if (value_errors + extra_stores + timeouts + file_errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
	input  logic                    clk,
	input  logic                    reset,
	output pipeline_pkg::word_t     imem_addr,
	input  pipeline_pkg::instr_t    imem_data,
	output pipeline_pkg::dmem_req_t dmem_req,
	input  pipeline_pkg::word_t     dmem_rdata
);

	pipeline_pkg::if_id_t    if_id;
	pipeline_pkg::id_ex_t    id_ex;
	pipeline_pkg::ex_mem_t   ex_mem;
	pipeline_pkg::redirect_t redirect;
	pipeline_pkg::wb_t       wb;
	pipeline_pkg::reg_addr_t rs;
	pipeline_pkg::reg_addr_t rt;
	pipeline_pkg::word_t     rs_data;
	pipeline_pkg::word_t     rt_data;
	logic                    stall;

	fetch_stage u_fetch (.clk(clk), .reset(reset), .stall(stall), .redirect(redirect),
		.imem_data(imem_data), .imem_addr(imem_addr), .if_id(if_id));

	decode_stage u_decode (.clk(clk), .reset(reset), .if_id(if_id), .stall(stall),
		.redirect(redirect), .rs_data(rs_data), .rt_data(rt_data), .rs(rs), .rt(rt),
		.id_ex(id_ex));

	reg_file u_reg_file (.clk(clk), .reset(reset), .rs(rs), .rt(rt), .rs_data(rs_data),
		.rt_data(rt_data), .wb(wb));

	hazard_unit u_hazard (.if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .stall(stall));

	execute_stage u_execute (.clk(clk), .reset(reset), .id_ex(id_ex), .wb(wb),
		.redirect(redirect), .ex_mem(ex_mem));

	// MEM/WB stays internal, only its writeback view leaves the stage
	memory_stage u_memory (.clk(clk), .reset(reset), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata),
		.dmem_req(dmem_req), .redirect(redirect), .mem_wb(), .wb(wb));

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  pipeline_pkg::ex_mem_t   ex_mem,
	input  pipeline_pkg::word_t     dmem_rdata,
	output pipeline_pkg::dmem_req_t dmem_req,
	output pipeline_pkg::redirect_t redirect,
	output pipeline_pkg::mem_wb_t   mem_wb,
	output pipeline_pkg::wb_t       wb
);

	logic branch_taken;

	assign branch_taken = (ex_mem.ctrl.branch_eq && ex_mem.zero) ||
		(ex_mem.ctrl.branch_ne && !ex_mem.zero);

	assign redirect.taken  = ex_mem.ctrl.jump || branch_taken;
	assign redirect.target = ex_mem.ctrl.jump ? ex_mem.jump_target : ex_mem.branch_target;

	// data port, answered in the same cycle
	assign dmem_req.addr  = ex_mem.alu_result;
	assign dmem_req.wdata = ex_mem.store_data;
	assign dmem_req.write = ex_mem.ctrl.mem_write;
	assign dmem_req.read  = ex_mem.ctrl.mem_read;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			mem_wb <= '0;
		else
		begin
			mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
			mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
			mem_wb.load_data  <= dmem_rdata;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.wr_addr    <= ex_mem.wr_addr;
		end
	end

	// writeback select
	assign wb.reg_write = mem_wb.reg_write;
	assign wb.wr_addr   = mem_wb.wr_addr;
	assign wb.data      = mem_wb.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  pipeline_pkg::id_ex_t    id_ex,
	input  pipeline_pkg::wb_t       wb,
	input  pipeline_pkg::redirect_t redirect,
	output pipeline_pkg::ex_mem_t   ex_mem
);

	pipeline_pkg::word_t     op_a;
	pipeline_pkg::word_t     rt_fwd;
	pipeline_pkg::word_t     op_b;
	pipeline_pkg::word_t     result;
	pipeline_pkg::alu_op_t   alu_op;
	pipeline_pkg::ex_mem_t   ex_mem_next;

	// EX/MEM has priority over writeback
	function automatic pipeline_pkg::fwd_sel_t fwd_select(input pipeline_pkg::reg_addr_t src);
		if (ex_mem.ctrl.reg_write && ex_mem.wr_addr != '0 && ex_mem.wr_addr == src)
			return pipeline_pkg::from_mem;
		if (wb.reg_write && wb.wr_addr != '0 && wb.wr_addr == src)
			return pipeline_pkg::from_wb;
		return pipeline_pkg::from_reg;
	endfunction

	function automatic pipeline_pkg::word_t operand(input pipeline_pkg::reg_addr_t src,
			input pipeline_pkg::word_t reg_val);
		case (fwd_select(src))
			pipeline_pkg::from_mem: return ex_mem.alu_result;
			pipeline_pkg::from_wb:  return wb.data;
			default:                return reg_val;
		endcase
	endfunction

	assign op_a   = operand(id_ex.rs, id_ex.rs_data);
	assign rt_fwd = operand(id_ex.rt, id_ex.rt_data);
	assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm_ext : rt_fwd;

	// alu control
	always_comb
	begin
		case (id_ex.ctrl.alu_class)
			pipeline_pkg::compare: alu_op = pipeline_pkg::alu_sub;
			pipeline_pkg::and_imm: alu_op = pipeline_pkg::alu_and;
			pipeline_pkg::rtype:
				case (id_ex.imm_ext[5:0])
					pipeline_pkg::fn_sub: alu_op = pipeline_pkg::alu_sub;
					pipeline_pkg::fn_and: alu_op = pipeline_pkg::alu_and;
					pipeline_pkg::fn_or:  alu_op = pipeline_pkg::alu_or;
					pipeline_pkg::fn_slt: alu_op = pipeline_pkg::alu_slt;
					default:              alu_op = pipeline_pkg::alu_add; // fn_add too
				endcase
			default: alu_op = pipeline_pkg::alu_add; // address calc, addi
		endcase
	end

	always_comb
	begin
		case (alu_op)
			pipeline_pkg::alu_sub: result = op_a - op_b;
			pipeline_pkg::alu_and: result = op_a & op_b;
			pipeline_pkg::alu_or:  result = op_a | op_b;
			pipeline_pkg::alu_slt: result = {31'b0, $signed(op_a) < $signed(op_b)};
			default:               result = op_a + op_b;
		endcase
	end

	always_comb
	begin
		ex_mem_next.ctrl          = id_ex.ctrl;
		ex_mem_next.jump_target   = id_ex.jump_target;
		ex_mem_next.branch_target = id_ex.pc_plus4 + {id_ex.imm_ext[29:0], 2'b00};
		ex_mem_next.zero          = (result == '0);
		ex_mem_next.alu_result    = result;
		ex_mem_next.store_data    = rt_fwd;
		ex_mem_next.wr_addr       = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex_mem <= '0;
		else if (redirect.taken)
			ex_mem <= '0;
		else
			ex_mem <= ex_mem_next;
	end

endmodule

// ==== hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  pipeline_pkg::if_id_t  if_id,
	input  pipeline_pkg::id_ex_t  id_ex,
	input  pipeline_pkg::ex_mem_t ex_mem,
	output logic                  stall
);

	pipeline_pkg::reg_addr_t rs;
	pipeline_pkg::reg_addr_t rt;
	logic                    is_store;
	logic                    store_after_load;
	logic                    store_after_load2;
	logic                    load_use;

	assign rs       = if_id.instr.i_fmt.rs;
	assign rt       = if_id.instr.i_fmt.rt;
	assign is_store = (if_id.instr.i_fmt.op == pipeline_pkg::op_sw);

	assign store_after_load  = is_store && id_ex.ctrl.mem_read && (rt == id_ex.rt);
	assign store_after_load2 = is_store && ex_mem.ctrl.mem_read && (rt == ex_mem.wr_addr);
	assign load_use = id_ex.ctrl.mem_read && ((rs == id_ex.rt) || (rt == id_ex.rt));

	assign stall = store_after_load || store_after_load2 || load_use;

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
	input  logic                    clk,
	input  logic                    reset,
	input  pipeline_pkg::reg_addr_t rs,
	input  pipeline_pkg::reg_addr_t rt,
	output pipeline_pkg::word_t     rs_data,
	output pipeline_pkg::word_t     rt_data,
	input  pipeline_pkg::wb_t       wb
);

	pipeline_pkg::word_t regs [32];

	function automatic pipeline_pkg::word_t read_port(input pipeline_pkg::reg_addr_t addr);
		if (addr == '0)
			return '0;
		if (wb.reg_write && wb.wr_addr == addr)
			return wb.data; // same-cycle write bypass
		return regs[addr];
	endfunction

	assign rs_data = read_port(rs);
	assign rt_data = read_port(rt);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.reg_write && wb.wr_addr != '0)
			regs[wb.wr_addr] <= wb.data;
	end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
	input  logic                    clk,
	input  logic                    reset,
	input  pipeline_pkg::if_id_t    if_id,
	input  logic                    stall,
	input  pipeline_pkg::redirect_t redirect,
	input  pipeline_pkg::word_t     rs_data,
	input  pipeline_pkg::word_t     rt_data,
	output pipeline_pkg::reg_addr_t rs,
	output pipeline_pkg::reg_addr_t rt,
	output pipeline_pkg::id_ex_t    id_ex
);

	pipeline_pkg::ctrl_t  ctrl;
	pipeline_pkg::id_ex_t id_ex_next;
	logic [5:0]           op;

	assign op = if_id.instr.i_fmt.op;
	assign rs = if_id.instr.i_fmt.rs;
	assign rt = if_id.instr.i_fmt.rt;

	// main control
	always_comb
	begin
		ctrl = '0;
		case (op)
			pipeline_pkg::op_lw:
			begin
				ctrl.mem_read   = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_write  = 1'b1;
				ctrl.alu_src    = 1'b1;
				ctrl.alu_class  = pipeline_pkg::mem_addr;
			end
			pipeline_pkg::op_sw:
			begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_class = pipeline_pkg::mem_addr;
			end
			pipeline_pkg::op_beq:
			begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_class = pipeline_pkg::compare;
			end
			pipeline_pkg::op_bne:
			begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_class = pipeline_pkg::compare;
			end
			pipeline_pkg::op_addi:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_class = pipeline_pkg::add_imm;
			end
			pipeline_pkg::op_andi:
			begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_class = pipeline_pkg::and_imm;
			end
			pipeline_pkg::op_j: ctrl.jump = 1'b1;
			default: // op_rtype and anything unknown
			begin
				ctrl.reg_write = 1'b1;
				ctrl.reg_dst   = 1'b1;
				ctrl.alu_class = pipeline_pkg::rtype;
			end
		endcase
	end

	always_comb
	begin
		id_ex_next.ctrl        = ctrl;
		id_ex_next.pc_plus4    = if_id.pc_plus4;
		id_ex_next.jump_target = {if_id.pc_plus4[31:28], if_id.instr.j_fmt.target, 2'b00};
		id_ex_next.rs_data     = rs_data;
		id_ex_next.rt_data     = rt_data;
		id_ex_next.imm_ext     = {{16{if_id.instr.i_fmt.imm[15]}}, if_id.instr.i_fmt.imm};
		id_ex_next.rs          = rs;
		id_ex_next.rt          = rt;
		id_ex_next.rd          = if_id.instr.r_fmt.rd;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			id_ex <= '0;
		else if (redirect.taken || stall)
			id_ex <= '0; // bubble
		else
			id_ex <= id_ex_next;
	end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   stall,
	input  pipeline_pkg::redirect_t redirect,
	input  pipeline_pkg::instr_t    imem_data,
	output pipeline_pkg::word_t     imem_addr,
	output pipeline_pkg::if_id_t    if_id
);

	pipeline_pkg::word_t pc;
	pipeline_pkg::word_t pc_plus4;

	assign pc_plus4  = pc + 32'd4;
	assign imem_addr = pc;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc    <= '0;
			if_id <= '0;
		end
		else if (redirect.taken) // redirect wins over a stall
		begin
			pc    <= redirect.target;
			if_id <= '0;
		end
		else if (!stall)
		begin
			pc             <= pc_plus4;
			if_id.pc_plus4 <= pc_plus4;
			if_id.instr    <= imem_data;
		end
	end

endmodule

// ==== pipeline_pkg.sv ====
package pipeline_pkg;

	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;

	// opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	// r-type function codes
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	typedef logic [data_width-1:0]     word_t;
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	typedef struct packed {
		logic [5:0] op;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] target;
	} j_fmt_t;

	// one instruction word, three ways to read it
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	typedef enum logic [2:0] {
		mem_addr, compare, rtype, add_imm, and_imm
	} alu_class_t;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_slt
	} alu_op_t;

	typedef enum logic [1:0] {
		from_reg, from_wb, from_mem
	} fwd_sel_t;

	typedef struct packed {
		logic       jump;
		logic       branch_eq;
		logic       branch_ne;
		logic       mem_read;
		logic       mem_write;
		logic       mem_to_reg;
		logic       reg_write;
		logic       reg_dst; // 1 = rd, 0 = rt
		logic       alu_src; // 1 = immediate
		alu_class_t alu_class;
	} ctrl_t;

	typedef struct packed {
		word_t  pc_plus4;
		instr_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     pc_plus4;
		word_t     jump_target;
		word_t     rs_data;
		word_t     rt_data;
		word_t     imm_ext; // low six bits double as funct
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     jump_target;
		word_t     branch_target;
		logic      zero;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t wr_addr;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		logic      mem_to_reg;
		word_t     load_data;
		word_t     alu_result;
		reg_addr_t wr_addr;
	} mem_wb_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} redirect_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic  write;
		logic  read;
	} dmem_req_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t wr_addr;
		word_t     data;
	} wb_t;

endpackage
